// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mem_stage.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/mem_pkg.sv
rtl/mem_control.sv
rtl/store_align.sv
rtl/load_extract.sv
rtl/mem_req_issue.sv
rtl/mem_stage.sv
verification/mem_stage_checker.sv
verification/mem_stage_tb.sv

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Major opcode, inst[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_ITYPE  = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_RTYPE  = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [2:0] {
        FNC_LB  = 3'b000,
        FNC_LH  = 3'b001,
        FNC_LW  = 3'b010,
        FNC_LBU = 3'b100,
        FNC_LHU = 3'b101
    } load_funct_e;

    typedef enum logic [2:0] {
        FNC_SB = 3'b000,
        FNC_SH = 3'b001,
        FNC_SW = 3'b010
    } store_funct_e;

    typedef enum logic [2:0] {
        FNC_BEQ  = 3'b000,
        FNC_BNE  = 3'b001,
        FNC_BLT  = 3'b100,
        FNC_BGE  = 3'b101,
        FNC_BLTU = 3'b110,
        FNC_BGEU = 3'b111
    } branch_funct_e;

endpackage

`default_nettype wire

// ==== rtl/load_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extract import isa_pkg::*; (
    input  logic        rsp_valid,
    input  logic [31:0] rsp_rdata,
    input  load_funct_e pend_funct,
    input  logic [1:0]  pend_off,
    output logic        load_valid,
    output logic [31:0] load_data
);

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // Responses come back in order, so no extra latency here
    assign load_valid = rsp_valid;

    assign lane_b = rsp_rdata[{pend_off, 3'b000} +: 8];
    assign lane_h = pend_off[1] ? rsp_rdata[31:16] : rsp_rdata[15:0];

    always_comb begin
        case (pend_funct)
            FNC_LB:  load_data = {{24{lane_b[7]}}, lane_b};
            FNC_LH:  load_data = {{16{lane_h[15]}}, lane_h};
            FNC_LBU: load_data = {24'd0, lane_b};
            FNC_LHU: load_data = {16'd0, lane_h};
            FNC_LW:  load_data = rsp_rdata;
            default: load_data = rsp_rdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mem_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_control import isa_pkg::*, mem_pkg::*; (
    input  logic [31:0] pc,
    input  logic [31:0] addr,
    input  logic [31:0] inst,
    input  logic [31:0] wb_inst,
    output mem_region_e region,
    output mem_size_e   size,
    output logic        is_load,
    output logic        is_store,
    output logic        din_sel,
    output logic        br_inst
);

    opcode_e     opcode;
    opcode_e     wb_opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs2;
    logic [4:0]  wb_rd;
    logic        wb_writes;

    assign opcode    = opcode_e'(inst[6:2]);
    assign funct3    = inst[14:12];
    assign rs2       = inst[24:20];
    assign wb_opcode = opcode_e'(wb_inst[6:2]);
    assign wb_rd     = wb_inst[11:7];

    // Instructions in writeback that update the register file
    always_comb begin
        case (wb_opcode)
            OPC_RTYPE, OPC_ITYPE, OPC_LOAD,
            OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC: wb_writes = 1'b1;
            default:                               wb_writes = 1'b0;
        endcase
    end

    always_comb begin
        region   = REGION_NONE;
        size     = MEM_SIZE_NONE;
        is_load  = 1'b0;
        is_store = 1'b0;
        din_sel  = 1'b0;
        br_inst  = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                is_load = 1'b1;
                // Unmapped addresses leave region at NONE
                casez (addr[31:28])
                    `ADDR_IO:   region = REGION_IO;
                    `ADDR_BIOS: region = REGION_BIOS;
                    `ADDR_DMEM: region = REGION_DMEM;
                    default:    region = REGION_NONE;
                endcase
            end
            OPC_STORE: begin
                is_store = 1'b1;
                if (addr[31:28] == `ADDR_IO) begin
                    region = REGION_IO;
                end else if (pc[30]) begin
                    // Code running from BIOS may write IMEM
                    region = REGION_IMEM;
                end else begin
                    region = REGION_DMEM;
                end

                case (store_funct_e'(funct3))
                    FNC_SB:  size = MEM_SIZE_BYTE;
                    FNC_SH:  size = MEM_SIZE_HALF;
                    FNC_SW:  size = MEM_SIZE_WORD;
                    default: size = MEM_SIZE_NONE;
                endcase

                // Store data still sitting in writeback
                din_sel = wb_writes && (wb_rd != 5'd0) && (wb_rd == rs2);
            end
            OPC_BRANCH: begin
                case (branch_funct_e'(funct3))
                    FNC_BEQ, FNC_BNE, FNC_BLT,
                    FNC_BGE, FNC_BLTU, FNC_BGEU: br_inst = 1'b1;
                    default:                     br_inst = 1'b0;
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Region patterns on addr[31:28], match with casez
`define ADDR_IO   4'b1000
`define ADDR_BIOS 4'b0100
`define ADDR_DMEM 4'b00?1

// Requests allowed in flight on the memory link
`define MEM_CREDITS 4

// Width of the credit counter, holds 0 to MEM_CREDITS
`define CREDIT_W 3

`endif

// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // Access width of a store
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2,
        MEM_SIZE_NONE = 2'd3
    } mem_size_e;

    // Target of a request on the memory link
    typedef enum logic [2:0] {
        REGION_NONE = 3'd0,
        REGION_IO   = 3'd1,
        REGION_BIOS = 3'd2,
        REGION_DMEM = 3'd3,
        REGION_IMEM = 3'd4
    } mem_region_e;

endpackage

`default_nettype wire

// ==== rtl/mem_req_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_req_issue import isa_pkg::*, mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  mem_region_e region,
    input  logic        is_load,
    input  logic        is_store,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wmask,
    input  load_funct_e funct3,
    input  logic        req_credit,
    input  logic        rsp_valid,
    output logic        in_ready,
    output logic        req_valid,
    output mem_region_e req_region,
    output logic [31:0] req_addr,
    output logic        req_we,
    output logic [31:0] req_wdata,
    output logic [3:0]  req_wmask,
    output load_funct_e pend_funct,
    output logic [1:0]  pend_off
);

    localparam int PTR_W = $clog2(`MEM_CREDITS);

    logic [`CREDIT_W-1:0] credits;
    logic                 need_req;
    logic                 accept;
    logic                 push;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    load_funct_e          q_funct [`MEM_CREDITS];
    logic [1:0]           q_off   [`MEM_CREDITS];

    // Unmapped loads go nowhere and never wait
    assign need_req = is_store || (is_load && (region != REGION_NONE));
    assign in_ready = !need_req || (credits != '0);
    assign accept   = in_valid && in_ready && need_req;
    assign push     = accept && is_load;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= `CREDIT_W'(`MEM_CREDITS);
        end else begin
            case ({accept, req_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_region <= region;
            req_addr   <= addr;
            req_we     <= is_store;
            req_wdata  <= wdata;
            req_wmask  <= wmask;
        end
    end

    // Pending loads, depth matches the credit count so it cannot overflow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rsp_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_funct[wr_ptr] <= funct3;
            q_off[wr_ptr]   <= addr[1:0];
        end
    end

    assign pend_funct = q_funct[rd_ptr];
    assign pend_off   = q_off[rd_ptr];

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage import isa_pkg::*, mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] pc,
    input  logic [31:0] addr,
    input  logic [31:0] inst,
    input  logic [31:0] store_data,
    input  logic [31:0] wb_inst,
    input  logic [31:0] wb_data,
    output logic        req_valid,
    output mem_region_e req_region,
    output logic [31:0] req_addr,
    output logic        req_we,
    output logic [31:0] req_wdata,
    output logic [3:0]  req_wmask,
    input  logic        req_credit,
    input  logic        rsp_valid,
    input  logic [31:0] rsp_rdata,
    output logic        load_valid,
    output logic [31:0] load_data,
    output logic        br_inst
);

    mem_region_e region;
    mem_size_e   size;
    logic        is_load;
    logic        is_store;
    logic        din_sel;
    logic [31:0] wdata;
    logic [3:0]  wmask;
    load_funct_e pend_funct;
    logic [1:0]  pend_off;

    mem_control mem_control_i (
        .pc       (pc),
        .addr     (addr),
        .inst     (inst),
        .wb_inst  (wb_inst),
        .region   (region),
        .size     (size),
        .is_load  (is_load),
        .is_store (is_store),
        .din_sel  (din_sel),
        .br_inst  (br_inst)
    );

    store_align store_align_i (
        .store_data (store_data),
        .wb_data    (wb_data),
        .din_sel    (din_sel),
        .size       (size),
        .byte_off   (addr[1:0]),
        .wdata      (wdata),
        .wmask      (wmask)
    );

    mem_req_issue mem_req_issue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .region     (region),
        .is_load    (is_load),
        .is_store   (is_store),
        .addr       (addr),
        .wdata      (wdata),
        .wmask      (wmask),
        .funct3     (load_funct_e'(inst[14:12])),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .in_ready   (in_ready),
        .req_valid  (req_valid),
        .req_region (req_region),
        .req_addr   (req_addr),
        .req_we     (req_we),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .pend_funct (pend_funct),
        .pend_off   (pend_off)
    );

    load_extract load_extract_i (
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .pend_funct (pend_funct),
        .pend_off   (pend_off),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// ==== rtl/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align import mem_pkg::*; (
    input  logic [31:0] store_data,
    input  logic [31:0] wb_data,
    input  logic        din_sel,
    input  mem_size_e   size,
    input  logic [1:0]  byte_off,
    output logic [31:0] wdata,
    output logic [3:0]  wmask
);

    logic [31:0] data;

    // Forwarding mux
    assign data = din_sel ? wb_data : store_data;

    always_comb begin
        case (size)
            MEM_SIZE_BYTE: begin
                wdata = {4{data[7:0]}};
                wmask = 4'b0001 << byte_off;
            end
            MEM_SIZE_HALF: begin
                wdata = {2{data[15:0]}};
                wmask = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SIZE_WORD: begin
                wdata = data;
                wmask = 4'b1111;
            end
            default: begin
                wdata = data;
                wmask = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verification/mem_stage_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_stage_checker (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic req_credit,
    input logic rsp_valid,
    input logic load_valid
);

    logic [`CREDIT_W-1:0] in_flight;
    int                   fail_cnt = 0;

    // Requests on the link whose credit has not come back yet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            case ({req_valid, req_credit})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight <= `CREDIT_W'(`MEM_CREDITS))
        else begin
            $error("more requests in flight than link credits");
            fail_cnt++;
        end

    request_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> in_flight < `CREDIT_W'(`MEM_CREDITS))
        else begin
            $error("request issued with every credit already consumed");
            fail_cnt++;
        end

    // Extraction adds no latency
    load_follows_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid == rsp_valid)
        else begin
            $error("load_valid differs from rsp_valid");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== verification/mem_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_stage_tb import isa_pkg::*, mem_pkg::*; ();

    localparam int NUM_TXN        = 400;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 20;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] pc;
    logic [31:0] addr;
    logic [31:0] inst;
    logic [31:0] store_data;
    logic [31:0] wb_inst;
    logic [31:0] wb_data;
    logic        req_valid;
    mem_region_e req_region;
    logic [31:0] req_addr;
    logic        req_we;
    logic [31:0] req_wdata;
    logic [3:0]  req_wmask;
    logic        req_credit;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        load_valid;
    logic [31:0] load_data;
    logic        br_inst;

    integer seed = 32'h1aa0_a427;
    int     err_cnt;
    int     cycle_cnt;
    int     req_cnt;
    int     load_cnt;

    // Reference model state
    int          model_credits;
    logic        exp_req;
    logic        exp_fwd;
    mem_region_e exp_region;
    logic        exp_we;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [3:0]  exp_wmask;
    logic [31:0] exp_loads [$];
    logic [31:0] ref_mem [5][64];

    // Memory side, answers in request order
    logic [31:0] mem_model [5][64];
    int          mq_due [$];
    logic        mq_load [$];
    logic [31:0] mq_data [$];

    mem_stage mem_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .pc         (pc),
        .addr       (addr),
        .inst       (inst),
        .store_data (store_data),
        .wb_inst    (wb_inst),
        .wb_data    (wb_data),
        .req_valid  (req_valid),
        .req_region (req_region),
        .req_addr   (req_addr),
        .req_we     (req_we),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .load_valid (load_valid),
        .load_data  (load_data),
        .br_inst    (br_inst)
    );

    bind mem_stage mem_stage_checker mem_stage_checker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .load_valid (load_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // Distinct start value for every region and word
    function automatic logic [31:0] fill_word(input int r, input int w);
        return (32'(r * 64 + w) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                               input logic [31:0] data,
                                               input logic [3:0]  mask);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        return word;
    endfunction

    function automatic mem_region_e load_region(input logic [31:0] a);
        if (a[31:28] == 4'b1000) begin
            return REGION_IO;
        end
        if (a[31:28] == 4'b0100) begin
            return REGION_BIOS;
        end
        if (a[31:30] == 2'b00 && a[28]) begin
            return REGION_DMEM;
        end
        return REGION_NONE;
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] word,
                                                input logic [2:0]  f3,
                                                input logic [1:0]  off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'd0, b};
            3'b101:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    // Opcodes that write rd
    function automatic logic writes_reg(input logic [4:0] opc);
        case (opc)
            5'b01100, 5'b00100, 5'b00000, 5'b11011,
            5'b11001, 5'b01101, 5'b00101: return 1'b1;
            default:                      return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        err_cnt++;
        $display("ERROR %s: expected %h, actual %h", test, exp_val, act_val);
    endtask

    task automatic complain(input string what);
        err_cnt++;
        $display("%s", what);
    endtask

    task automatic make_txn();
        logic [31:0] r;
        logic [31:0] ra;
        logic [31:0] rw;
        logic [4:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rs2;
        logic [4:0]  wb_opc;
        logic [4:0]  wb_rd;
        logic [3:0]  top;
        r  = rand32();
        ra = rand32();
        rw = rand32();
        case (r[1:0])
            2'd0: begin
                opc = 5'b00000;
                case (r[4:2])
                    3'd0, 3'd5: f3 = 3'b000;
                    3'd1:       f3 = 3'b001;
                    3'd2, 3'd6: f3 = 3'b010;
                    3'd3:       f3 = 3'b100;
                    default:    f3 = 3'b101;
                endcase
            end
            2'd1: begin
                opc = 5'b01000;
                f3  = (r[3:2] == 2'd3) ? 3'b010 : {1'b0, r[3:2]};
            end
            2'd2: begin
                opc = 5'b11000;
                f3  = r[6:4];
            end
            default: begin
                case (r[4:2])
                    3'd0:    opc = 5'b01100;
                    3'd1:    opc = 5'b00100;
                    3'd2:    opc = 5'b01101;
                    3'd3:    opc = 5'b00101;
                    3'd4:    opc = 5'b11011;
                    default: opc = 5'b11001;
                endcase
                f3 = r[7:5];
            end
        endcase
        // Top nibble picks a region or an unmapped hole
        case (ra[30:28])
            3'd0:    top = 4'b1000;
            3'd1:    top = 4'b0100;
            3'd2:    top = 4'b0001;
            3'd3:    top = 4'b0011;
            3'd4:    top = 4'b0000;
            3'd5:    top = 4'b0110;
            3'd6:    top = 4'b1100;
            default: top = 4'b0010;
        endcase
        case (rw[2:0])
            3'd0:    wb_opc = 5'b01100;
            3'd1:    wb_opc = 5'b00100;
            3'd2:    wb_opc = 5'b00000;
            3'd3:    wb_opc = 5'b11011;
            3'd4:    wb_opc = 5'b01101;
            3'd5:    wb_opc = 5'b01000;
            3'd6:    wb_opc = 5'b11000;
            default: wb_opc = 5'b00101;
        endcase
        rs2        = {3'b000, r[9:8]};
        wb_rd      = rw[4] ? rs2 : {3'b000, rw[6:5]};
        addr       = {top, 20'd0, ra[7:0]};
        pc         = {1'b0, ra[12], ra[27:0], 2'b00};
        inst       = {r[31:25], rs2, r[19:15], f3, r[11:10], 3'b000, opc, 2'b11};
        wb_inst    = {rw[31:12], wb_rd, wb_opc, 2'b11};
        store_data = rand32();
        wb_data    = rand32();
        in_valid   = 1'b1;
    endtask

    task automatic check_decode_outputs();
        logic [4:0] opc;
        logic [2:0] f3;
        logic       need;
        logic       exp_br;
        opc    = inst[6:2];
        f3     = inst[14:12];
        need   = (opc == 5'b01000) || (opc == 5'b00000 && load_region(addr) != REGION_NONE);
        exp_br = (opc == 5'b11000) && (f3 != 3'b010) && (f3 != 3'b011);
        assert (in_ready == (!need || model_credits > 0))
            else report_mismatch("credit_ready", 32'(!need || model_credits > 0), 32'(in_ready));
        assert (br_inst == exp_br)
            else report_mismatch("branch_flag", 32'(exp_br), 32'(br_inst));
    endtask

    task automatic check_request();
        string wtest;
        assert (req_valid == exp_req)
            else complain("Request missing or extra in the cycle after acceptance");
        if (req_valid && exp_req) begin
            req_cnt++;
            wtest = exp_fwd ? "forwarding" : "store_align";
            assert (req_region == exp_region)
                else report_mismatch("region_decode", 32'(exp_region), 32'(req_region));
            assert (req_we == exp_we)
                else report_mismatch("region_decode", 32'(exp_we), 32'(req_we));
            assert (req_addr == exp_addr)
                else report_mismatch("region_decode", exp_addr, req_addr);
            if (exp_we) begin
                assert (req_wdata == exp_wdata)
                    else report_mismatch(wtest, exp_wdata, req_wdata);
                assert (req_wmask == exp_wmask)
                    else report_mismatch(wtest, 32'(exp_wmask), 32'(req_wmask));
            end
        end
        if (req_valid) begin
            if (req_we) begin
                mem_model[req_region][req_addr[7:2]] =
                    merge_word(mem_model[req_region][req_addr[7:2]], req_wdata, req_wmask);
            end
            mq_due.push_back(cycle_cnt + 1 + int'(rand32() % 32'd6));
            mq_load.push_back(!req_we);
            mq_data.push_back(mem_model[req_region][req_addr[7:2]]);
            assert (mq_due.size() <= `MEM_CREDITS)
                else complain("More than four requests outstanding on the link");
        end
    endtask

    task automatic check_load_response();
        logic [31:0] exp_val;
        assert (load_valid == rsp_valid)
            else complain("load_valid does not follow rsp_valid");
        if (rsp_valid) begin
            if (exp_loads.size() == 0) begin
                complain("Load response arrived with no load pending");
            end else begin
                exp_val = exp_loads.pop_front();
                load_cnt++;
                assert (load_data == exp_val)
                    else report_mismatch("load_extract", exp_val, load_data);
            end
        end
    endtask

    // Reference model for one accepted instruction
    task automatic accept_txn();
        logic [4:0]  opc;
        logic [2:0]  f3;
        logic [31:0] src;
        mem_region_e r;
        opc     = inst[6:2];
        f3      = inst[14:12];
        exp_fwd = 1'b0;
        if (opc == 5'b00000) begin
            r = load_region(addr);
            if (r != REGION_NONE) begin
                exp_req    = 1'b1;
                exp_region = r;
                exp_we     = 1'b0;
                exp_addr   = addr;
                exp_loads.push_back(extend_load(ref_mem[r][addr[7:2]], f3, addr[1:0]));
            end
        end else if (opc == 5'b01000) begin
            exp_fwd = writes_reg(wb_inst[6:2]) && (wb_inst[11:7] != 5'd0)
                      && (wb_inst[11:7] == inst[24:20]);
            src = exp_fwd ? wb_data : store_data;
            if (addr[31:28] == 4'b1000) begin
                r = REGION_IO;
            end else if (pc[30]) begin
                r = REGION_IMEM;
            end else begin
                r = REGION_DMEM;
            end
            // Lane by lane, byte b of the word bus
            for (int b = 0; b < 4; b++) begin
                case (f3)
                    3'b000: begin
                        exp_wdata[8*b +: 8] = src[7:0];
                        exp_wmask[b]        = (b == addr[1:0]);
                    end
                    3'b001: begin
                        exp_wdata[8*b +: 8] = src[8*(b%2) +: 8];
                        exp_wmask[b]        = ((b / 2) == addr[1]);
                    end
                    default: begin
                        exp_wdata[8*b +: 8] = src[8*b +: 8];
                        exp_wmask[b]        = 1'b1;
                    end
                endcase
            end
            ref_mem[r][addr[7:2]] = merge_word(ref_mem[r][addr[7:2]], exp_wdata, exp_wmask);
            exp_req    = 1'b1;
            exp_region = r;
            exp_we     = 1'b1;
            exp_addr   = addr;
        end
        if (exp_req) begin
            model_credits--;
        end
    endtask

    // Sample between edges, where every input and output is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_valid) begin
                check_decode_outputs();
            end
            check_request();
            check_load_response();
            exp_req = 1'b0;
            if (in_valid && in_ready) begin
                accept_txn();
            end
            if (req_credit) begin
                model_credits++;
            end
        end
    end

    // One credit per cycle, a load also gets its data
    always @(posedge clk) begin
        #1;
        req_credit = 1'b0;
        rsp_valid  = 1'b0;
        if (mq_due.size() > 0 && mq_due[0] <= cycle_cnt) begin
            req_credit = 1'b1;
            rsp_valid  = mq_load[0];
            rsp_rdata  = mq_data[0];
            void'(mq_due.pop_front());
            void'(mq_load.pop_front());
            void'(mq_data.pop_front());
        end
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        pc            = 32'd0;
        addr          = 32'd0;
        inst          = 32'h0000_0013;
        store_data    = 32'd0;
        wb_inst       = 32'd0;
        wb_data       = 32'd0;
        req_credit    = 1'b0;
        rsp_valid     = 1'b0;
        rsp_rdata     = 32'd0;
        err_cnt       = 0;
        cycle_cnt     = 0;
        req_cnt       = 0;
        load_cnt      = 0;
        model_credits = `MEM_CREDITS;
        exp_req       = 1'b0;
        for (int r = 0; r < 5; r++) begin
            for (int w = 0; w < 64; w++) begin
                ref_mem[r][w]   = fill_word(r, w);
                mem_model[r][w] = fill_word(r, w);
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < NUM_TXN; n++) begin
            make_txn();
            // Inputs stay put until the stage takes them
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        repeat (2) @(posedge clk);
        while (mq_due.size() > 0 || exp_loads.size() > 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        assert (model_credits == `MEM_CREDITS)
            else complain("Not every credit came back by the end of the run");
        err_cnt += mem_stage_i.mem_stage_checker_i.fail_cnt;
        $display("Requests %0d, loads %0d, errors %0d", req_cnt, load_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
